// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // datapath widths
    localparam int ADDR_W = 32;
    localparam int INST_W = 32;

    // queue holds QUEUE_DEPTH-1 words, full when tail+1 == head
    localparam int QUEUE_DEPTH = 16;
    localparam int PTR_W       = 4;

    localparam int ID_W = 64;   // running instruction id

    // instruction memory model
    localparam int MEM_WORDS   = 256;
    localparam int MEM_ADDR_W  = 8;
    localparam int MEM_LATENCY = 2;    // accept to response, in cycles
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

    localparam string MEM_INIT_FILE = "sim/program.hex";

    localparam logic [ADDR_W-1:0] RESET_PC = '0;

    // fetch controller states
    localparam logic FETCH_IDLE = 1'b0;   // nothing outstanding
    localparam logic FETCH_WAIT = 1'b1;   // one request in flight

endpackage

// ==== hw/fetch_ctrl.sv ====
module fetch_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        redirect_valid,
    input  logic [fetch_pkg::ADDR_W-1:0] redirect_addr,
    input  logic                        mem_req_ready,
    input  logic                        mem_resp_valid,
    input  logic [fetch_pkg::ADDR_W-1:0] mem_resp_addr,
    input  logic                        full,
    input  logic                        empty,
    output logic                        mem_req_valid,
    output logic [fetch_pkg::ADDR_W-1:0] mem_req_addr,
    output logic                        push,
    output logic                        flush
);
    import fetch_pkg::*;

    logic              state;
    logic [ADDR_W-1:0] next_pc;    // next sequential fetch address
    logic [ADDR_W-1:0] req_addr;   // address of the request in flight
    logic              hazard;
    logic              accept;
    logic              resp_match;

    // a redirect to the word already in flight with nothing buffered
    // is just a slow fetch, anything else throws the queue away
    assign hazard = redirect_valid &&
                    !(state == FETCH_WAIT && req_addr == redirect_addr && empty);

    assign mem_req_valid = hazard || !full;
    assign mem_req_addr  = redirect_valid ? redirect_addr : next_pc;
    assign accept        = mem_req_valid && mem_req_ready;

    // stale responses from before a redirect fail the address compare
    assign resp_match = (state == FETCH_WAIT) && mem_resp_valid &&
                        (mem_resp_addr == req_addr);

    assign push  = resp_match && !hazard;
    assign flush = hazard;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= FETCH_IDLE;
            next_pc <= RESET_PC;
        end else if (hazard) begin
            if (mem_req_ready) begin
                state    <= FETCH_WAIT;    // target requested this cycle
                req_addr <= redirect_addr;
                next_pc  <= redirect_addr + ADDR_W'(4);
            end else begin
                state   <= FETCH_IDLE;
                next_pc <= redirect_addr;  // request it once memory is free
            end
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (accept) begin
                        state    <= FETCH_WAIT;
                        req_addr <= mem_req_addr;
                        next_pc  <= mem_req_addr + ADDR_W'(4);
                    end
                end
                FETCH_WAIT: begin
                    if (resp_match) begin
                        if (accept) begin
                            // chain the next request behind the response
                            req_addr <= mem_req_addr;
                            next_pc  <= mem_req_addr + ADDR_W'(4);
                        end else begin
                            state <= FETCH_IDLE;
                        end
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/fetch_queue_counters.sv ====
module fetch_queue_counters (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic                       flush,
    input  logic                       inst_ready,
    output logic                       full,
    output logic                       empty,
    output logic [fetch_pkg::PTR_W-1:0] head,
    output logic [fetch_pkg::PTR_W-1:0] tail,
    output logic                       inst_valid,
    output logic [fetch_pkg::ID_W-1:0]  inst_id
);
    import fetch_pkg::*;

    logic take;   // decode side accepts a word

    assign empty = (head == tail);
    assign full  = (tail + PTR_W'(1)) == head;   // one slot kept free

    // a push into an empty queue is visible in the same cycle
    assign inst_valid = !empty || push;
    assign take       = inst_valid && inst_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push)
                tail <= tail + PTR_W'(1);
            if (flush)
                head <= tail;              // drop everything buffered
            else if (take)
                head <= head + PTR_W'(1);
        end
    end

    // id also steps once per hazard
    always_ff @(posedge clk) begin
        if (rst)
            inst_id <= '0;
        else if (flush || take)
            inst_id <= inst_id + ID_W'(1);
    end

endmodule

// ==== hw/inst_queue_ram.sv ====
module inst_queue_ram (
    input  logic                        clk,
    input  logic                        push,
    input  logic [fetch_pkg::PTR_W-1:0]  tail,
    input  logic [fetch_pkg::PTR_W-1:0]  head,
    input  logic                        empty,
    input  logic [fetch_pkg::ADDR_W-1:0] mem_resp_addr,
    input  logic [fetch_pkg::INST_W-1:0] mem_resp_inst,
    output logic [fetch_pkg::ADDR_W-1:0] inst_addr,
    output logic [fetch_pkg::INST_W-1:0] inst_word
);
    import fetch_pkg::*;

    logic [ADDR_W-1:0] addr_mem [QUEUE_DEPTH];
    logic [INST_W-1:0] word_mem [QUEUE_DEPTH];

    // written at the tail, even when the word also leaves through the bypass
    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[tail] <= mem_resp_addr;
            word_mem[tail] <= mem_resp_inst;
        end
    end

    // empty queue means the memory response goes straight out
    assign inst_addr = empty ? mem_resp_addr : addr_mem[head];
    assign inst_word = empty ? mem_resp_inst : word_mem[head];

endmodule

// ==== hw/inst_mem.sv ====
module inst_mem (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        mem_req_valid,
    input  logic [fetch_pkg::ADDR_W-1:0] mem_req_addr,
    output logic                        mem_req_ready,
    output logic                        mem_resp_valid,
    output logic [fetch_pkg::ADDR_W-1:0] mem_resp_addr,
    output logic [fetch_pkg::INST_W-1:0] mem_resp_inst
);
    import fetch_pkg::*;

    logic [INST_W-1:0]    mem [MEM_WORDS];
    logic                 busy;        // request accepted, response pending
    logic [LAT_CNT_W-1:0] lat_cnt;
    logic [ADDR_W-1:0]    addr_q;
    logic                 accept;

    initial begin
        $readmemh(MEM_INIT_FILE, mem);
    end

    assign mem_req_ready = !busy;      // one request at a time
    assign accept        = mem_req_valid && mem_req_ready;

    assign mem_resp_valid = busy && (lat_cnt == LAT_CNT_W'(MEM_LATENCY));
    assign mem_resp_addr  = addr_q;
    assign mem_resp_inst  = mem[addr_q[MEM_ADDR_W+1:2]];   // word index

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            lat_cnt <= LAT_CNT_W'(1);
        end else if (busy) begin
            if (mem_resp_valid) begin
                busy    <= 1'b0;       // ready again after the response cycle
                lat_cnt <= '0;
            end else begin
                lat_cnt <= lat_cnt + LAT_CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            addr_q <= mem_req_addr;
    end

endmodule

// ==== hw/fetch_unit.sv ====
module fetch_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        redirect_valid,
    input  logic [fetch_pkg::ADDR_W-1:0] redirect_addr,
    input  logic                        inst_ready,
    output logic                        inst_valid,
    output logic [fetch_pkg::ADDR_W-1:0] inst_addr,
    output logic [fetch_pkg::INST_W-1:0] inst_word,
    output logic [fetch_pkg::ID_W-1:0]   inst_id
);
    import fetch_pkg::*;

    // memory side
    logic              mem_req_valid;
    logic              mem_req_ready;
    logic [ADDR_W-1:0] mem_req_addr;
    logic              mem_resp_valid;
    logic [ADDR_W-1:0] mem_resp_addr;
    logic [INST_W-1:0] mem_resp_inst;

    // queue control
    logic             push;
    logic             flush;
    logic             full;
    logic             empty;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    fetch_ctrl fetch_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_addr  (mem_resp_addr),
        .full           (full),
        .empty          (empty),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .push           (push),
        .flush          (flush)
    );

    fetch_queue_counters fetch_queue_counters_i (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .flush      (flush),
        .inst_ready (inst_ready),
        .full       (full),
        .empty      (empty),
        .head       (head),
        .tail       (tail),
        .inst_valid (inst_valid),
        .inst_id    (inst_id)
    );

    inst_queue_ram inst_queue_ram_i (
        .clk           (clk),
        .push          (push),
        .tail          (tail),
        .head          (head),
        .empty         (empty),
        .mem_resp_addr (mem_resp_addr),
        .mem_resp_inst (mem_resp_inst),
        .inst_addr     (inst_addr),
        .inst_word     (inst_word)
    );

    inst_mem inst_mem_i (
        .clk            (clk),
        .rst            (rst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_addr  (mem_resp_addr),
        .mem_resp_inst  (mem_resp_inst)
    );

endmodule

// ==== sim/fetch_unit_tb.sv ====
module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int RESET_LEN   = 4;
    localparam int TEST_CYCLES = 1500;   // rough length of all sections
    localparam int SEED        = 97;

    logic              clk;
    logic              rst;
    logic              redirect_valid;
    logic [ADDR_W-1:0] redirect_addr;
    logic              inst_ready;
    logic              inst_valid;
    logic [ADDR_W-1:0] inst_addr;
    logic [INST_W-1:0] inst_word;
    logic [ID_W-1:0]   inst_id;

    // reference model state
    logic [INST_W-1:0] prog [MEM_WORDS];
    logic [ADDR_W-1:0] exp_addr;
    logic [ID_W-1:0]   exp_id;
    logic [INST_W-1:0] exp_word;
    logic              redirect_slow;   // next redirect is a slow fetch, not a hazard
    logic              drain_check;

    fetch_unit fetch_unit_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .inst_ready     (inst_ready),
        .inst_valid     (inst_valid),
        .inst_addr      (inst_addr),
        .inst_word      (inst_word),
        .inst_id        (inst_id)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign exp_word = prog[exp_addr[9:2]];

    always @(posedge clk) begin
        if (rst) begin
            exp_addr <= RESET_PC;
            exp_id   <= '0;
        end else if (redirect_valid) begin
            if (!redirect_slow) begin   // queue dropped, id steps once
                exp_addr <= redirect_addr;
                exp_id   <= exp_id + ID_W'(1);
            end
        end else if (inst_valid && inst_ready) begin
            exp_addr <= exp_addr + ADDR_W'(4);
            exp_id   <= exp_id + ID_W'(1);
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, want);
        $display("Done: errors found");
        $fatal(1, "value check failed");
    endtask

    task automatic report_failure(input string what);
        $display("[ERROR] %0t ns %s", $time, what);
        $display("Done: errors found");
        $fatal(1, "check failed");
    endtask

    // every accepted word
    assert property (@(posedge clk) disable iff (rst)
        (inst_valid && inst_ready) |-> inst_addr == exp_addr)
        else report_mismatch("inst_addr", 64'($sampled(inst_addr)),
                             64'($sampled(exp_addr)));

    assert property (@(posedge clk) disable iff (rst)
        (inst_valid && inst_ready) |-> inst_word == exp_word)
        else report_mismatch("inst_word", 64'($sampled(inst_word)),
                             64'($sampled(exp_word)));

    assert property (@(posedge clk) disable iff (rst)
        (inst_valid && inst_ready) |-> inst_id == exp_id)
        else report_mismatch("inst_id", $sampled(inst_id), $sampled(exp_id));

    assert property (@(posedge clk) rst |-> !inst_valid)
        else report_failure("inst_valid high during reset");

    assert property (@(posedge clk) $fell(rst) |-> !inst_valid)
        else report_failure("inst_valid high right after reset");

    assert property (@(posedge clk) disable iff (rst) drain_check |-> inst_valid)
        else report_failure("inst_valid dropped while draining the queue");

    task automatic wait_words(input int n);
        int count;
        count = 0;
        while (count < n) begin
            @(posedge clk);
            if (inst_valid && inst_ready)
                count++;
        end
    endtask

    // one-cycle redirect strobe, decode side held off meanwhile
    task automatic send_redirect();
        @(negedge clk);
        inst_ready     = 1'b0;
        redirect_valid = 1'b1;
        redirect_addr  = new_target();   // picked once exp_addr has settled
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    function automatic logic [ADDR_W-1:0] new_target();
        logic [ADDR_W-1:0] t;
        t = ADDR_W'($urandom_range(0, MEM_WORDS - 1)) << 2;
        if (t == exp_addr)
            t = t + ADDR_W'(4);
        return t;
    endfunction

    // lines up with the cycle after an accepted request on an empty queue,
    // then redirects to the address in flight
    task automatic slow_redirect();
        logic [2:0] hist;
        hist = 3'b111;
        @(negedge clk);
        inst_ready = 1'b1;
        while (hist != 3'b001) begin
            @(posedge clk);
            hist = {hist[1:0], inst_valid};
        end
        @(negedge clk);   // request for exp_addr accepted here
        @(negedge clk);
        inst_ready     = 1'b0;
        redirect_valid = 1'b1;
        redirect_addr  = exp_addr;
        redirect_slow  = 1'b1;
        @(negedge clk);
        redirect_valid = 1'b0;
        redirect_slow  = 1'b0;
        inst_ready     = 1'b1;
    endtask

    initial begin
        #(TEST_CYCLES * 20 * CLK_PERIOD);
        $display("timeout: fetch unit stopped delivering words");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(SEED));
        $readmemh(MEM_INIT_FILE, prog);
        clk            = 1'b0;
        rst            = 1'b1;
        inst_ready     = 1'b0;
        redirect_valid = 1'b0;
        redirect_addr  = '0;
        redirect_slow  = 1'b0;
        drain_check    = 1'b0;

        repeat (RESET_LEN) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // free running fetch
        inst_ready = 1'b1;
        wait_words(30);

        // back-pressure fills the queue, then drain
        @(negedge clk);
        inst_ready = 1'b0;
        repeat (40) @(negedge clk);
        inst_ready  = 1'b1;
        drain_check = 1'b1;
        repeat (QUEUE_DEPTH - 1) @(negedge clk);
        drain_check = 1'b0;
        wait_words(20);

        // redirect with the queue mostly idle, then with it full
        send_redirect();
        inst_ready = 1'b1;
        wait_words(10);
        repeat (20) @(negedge clk);
        inst_ready = 1'b0;
        repeat (60) @(negedge clk);
        send_redirect();
        inst_ready = 1'b1;
        wait_words(10);

        repeat (3) begin
            slow_redirect();
            wait_words(8);
        end

        // random decode stalls and redirects
        for (int i = 0; i < 30; i++) begin
            repeat ($urandom_range(1, 10)) begin
                @(negedge clk);
                inst_ready = 1'($urandom_range(0, 1));
            end
            send_redirect();
        end
        inst_ready = 1'b1;
        wait_words(20);

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== sim/program.hex ====
// eight instruction words per line, word i sits at byte address 4*i
// word i = {i, 00, i, 13}
00000013 01000113 02000213 03000313 04000413 05000513 06000613 07000713
08000813 09000913 0a000a13 0b000b13 0c000c13 0d000d13 0e000e13 0f000f13
10001013 11001113 12001213 13001313 14001413 15001513 16001613 17001713
18001813 19001913 1a001a13 1b001b13 1c001c13 1d001d13 1e001e13 1f001f13
20002013 21002113 22002213 23002313 24002413 25002513 26002613 27002713
28002813 29002913 2a002a13 2b002b13 2c002c13 2d002d13 2e002e13 2f002f13
30003013 31003113 32003213 33003313 34003413 35003513 36003613 37003713
38003813 39003913 3a003a13 3b003b13 3c003c13 3d003d13 3e003e13 3f003f13
40004013 41004113 42004213 43004313 44004413 45004513 46004613 47004713
48004813 49004913 4a004a13 4b004b13 4c004c13 4d004d13 4e004e13 4f004f13
50005013 51005113 52005213 53005313 54005413 55005513 56005613 57005713
58005813 59005913 5a005a13 5b005b13 5c005c13 5d005d13 5e005e13 5f005f13
60006013 61006113 62006213 63006313 64006413 65006513 66006613 67006713
68006813 69006913 6a006a13 6b006b13 6c006c13 6d006d13 6e006e13 6f006f13
70007013 71007113 72007213 73007313 74007413 75007513 76007613 77007713
78007813 79007913 7a007a13 7b007b13 7c007c13 7d007d13 7e007e13 7f007f13
80008013 81008113 82008213 83008313 84008413 85008513 86008613 87008713
88008813 89008913 8a008a13 8b008b13 8c008c13 8d008d13 8e008e13 8f008f13
90009013 91009113 92009213 93009313 94009413 95009513 96009613 97009713
98009813 99009913 9a009a13 9b009b13 9c009c13 9d009d13 9e009e13 9f009f13
a000a013 a100a113 a200a213 a300a313 a400a413 a500a513 a600a613 a700a713
a800a813 a900a913 aa00aa13 ab00ab13 ac00ac13 ad00ad13 ae00ae13 af00af13
b000b013 b100b113 b200b213 b300b313 b400b413 b500b513 b600b613 b700b713
b800b813 b900b913 ba00ba13 bb00bb13 bc00bc13 bd00bd13 be00be13 bf00bf13
c000c013 c100c113 c200c213 c300c313 c400c413 c500c513 c600c613 c700c713
c800c813 c900c913 ca00ca13 cb00cb13 cc00cc13 cd00cd13 ce00ce13 cf00cf13
d000d013 d100d113 d200d213 d300d313 d400d413 d500d513 d600d613 d700d713
d800d813 d900d913 da00da13 db00db13 dc00dc13 dd00dd13 de00de13 df00df13
e000e013 e100e113 e200e213 e300e313 e400e413 e500e513 e600e613 e700e713
e800e813 e900e913 ea00ea13 eb00eb13 ec00ec13 ed00ed13 ee00ee13 ef00ef13
f000f013 f100f113 f200f213 f300f313 f400f413 f500f513 f600f613 f700f713
f800f813 f900f913 fa00fa13 fb00fb13 fc00fc13 fd00fd13 fe00fe13 ff00ff13

// ==== project.f ====
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/fetch_queue_counters.sv
hw/inst_queue_ram.sv
hw/inst_mem.sv
hw/fetch_unit.sv
sim/fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run from the project root; exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module fetch_unit_tb \
    -o fetch_unit_sim &&
./obj_dir/fetch_unit_sim || {
    echo "simulation failed"
    exit 1
}
